// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= torus_router_tb
FILELIST  ?= torus_router.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, not the exit status of the binary
run: compile
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/dor_route.sv ====
module dor_route #(
    parameter torus_router_pkg::coord_t cur = '0
) (
    input  torus_router_pkg::coord_t dst,
    output torus_router_pkg::dir_e   route
);

    // x first, then y, then z; no wrap links
    always_comb begin
        if (dst.x > cur.x) begin
            route = torus_router_pkg::DIR_XPOS;
        end else if (dst.x < cur.x) begin
            route = torus_router_pkg::DIR_XNEG;
        end else if (dst.y > cur.y) begin
            route = torus_router_pkg::DIR_YPOS;
        end else if (dst.y < cur.y) begin
            route = torus_router_pkg::DIR_YNEG;
        end else if (dst.z > cur.z) begin
            route = torus_router_pkg::DIR_ZPOS;
        end else if (dst.z < cur.z) begin
            route = torus_router_pkg::DIR_ZNEG;
        end else begin
            // arrived
            route = torus_router_pkg::DIR_LOCAL;
        end
    end

endmodule

// ==== source/flit_queue.sv ====
module flit_queue #(
    parameter int depth = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  torus_router_pkg::flit_t wr_data,
    input  logic                    rd_en,
    output torus_router_pkg::flit_t head,
    output logic                    empty
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = PTR_W + 1;
    localparam logic [PTR_W-1:0] LAST_SLOT  = PTR_W'(depth - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(depth);

    torus_router_pkg::flit_t mem [depth];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // oldest entry, never valid while empty
    always_comb begin
        head       = mem[rd_ptr];
        head.valid = mem[rd_ptr].valid && !empty;
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/input_port.sv ====
module input_port #(
    parameter torus_router_pkg::coord_t cur         = '0,
    parameter int                       queue_depth = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  torus_router_pkg::flit_t   link_in,
    input  logic                      grant,
    output torus_router_pkg::sw_req_t req,
    output torus_router_pkg::flit_t   eject
);

    torus_router_pkg::flit_t head;
    torus_router_pkg::dir_e  route;
    logic                    empty;
    logic                    is_local;
    logic                    pop;

    ////////////////////
    // queue and route

    flit_queue #(
        .depth(queue_depth)
    ) u_queue (
        .clk    (clk),
        .rst    (rst),
        .wr_en  (link_in.valid),
        .wr_data(link_in),
        .rd_en  (pop),
        .head   (head),
        .empty  (empty)
    );

    dor_route #(
        .cur(cur)
    ) u_route (
        .dst  (head.dst),
        .route(route)
    );

    assign is_local = !empty && (route == torus_router_pkg::DIR_LOCAL);

    // local heads leave at once, others wait for the switch
    assign pop = is_local || (grant && req.flit.valid);

    ////////////////////
    // switch request

    // held steady until granted since the head does not move
    always_comb begin
        req.flit       = head;
        req.flit.valid = !empty && !is_local;
        req.route      = route;
    end

    ////////////////////
    // eject to kernel

    always_ff @(posedge clk) begin
        if (rst) begin
            eject.valid <= 1'b0;
        end else begin
            eject       <= head;
            eject.valid <= is_local;
        end
    end

endmodule

// ==== source/switch_alloc.sv ====
module switch_alloc (
    input  logic                      clk,
    input  logic                      rst,
    input  torus_router_pkg::sw_req_t req    [torus_router_pkg::NUM_PORTS],
    input  torus_router_pkg::flit_t   inject [torus_router_pkg::NUM_PORTS],
    output logic                      grant  [torus_router_pkg::NUM_PORTS],
    output torus_router_pkg::flit_t   out    [torus_router_pkg::NUM_PORTS]
);

    localparam int NUM_PORTS = torus_router_pkg::NUM_PORTS;
    localparam int IDX_W     = $clog2(NUM_PORTS);

    typedef logic [IDX_W-1:0] port_idx_t;

    localparam port_idx_t LAST_IDX = port_idx_t'(NUM_PORTS - 1);

    // want[d][i] means input i asks for output d
    logic [NUM_PORTS-1:0] want [NUM_PORTS];

    port_idx_t rr_ptr    [NUM_PORTS];
    port_idx_t win_idx   [NUM_PORTS];
    logic      win_valid [NUM_PORTS];

    ////////////////////
    // request matrix

    always_comb begin
        for (int d = 0; d < NUM_PORTS; d++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                want[d][i] = req[i].flit.valid && (int'(req[i].route) == d + 1);
            end
        end
    end

    ////////////////////
    // round robin

    always_comb begin
        int idx;
        idx = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            grant[i] = 1'b0;
        end
        for (int d = 0; d < NUM_PORTS; d++) begin
            win_valid[d] = 1'b0;
            win_idx[d]   = '0;
            // scan backwards from the pointer so the nearest hit lands last
            for (int k = NUM_PORTS - 1; k >= 0; k--) begin
                idx = int'(rr_ptr[d]) + k;
                if (idx >= NUM_PORTS) begin
                    idx = idx - NUM_PORTS;
                end
                if (want[d][idx]) begin
                    win_valid[d] = 1'b1;
                    win_idx[d]   = port_idx_t'(idx);
                end
            end
            // kernel inject owns the output this cycle
            if (inject[d].valid) begin
                win_valid[d] = 1'b0;
            end
            if (win_valid[d]) begin
                grant[win_idx[d]] = 1'b1;
            end
        end
    end

    ////////////////////
    // output registers

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int d = 0; d < NUM_PORTS; d++) begin
                rr_ptr[d]    <= '0;
                out[d].valid <= 1'b0;
            end
        end else begin
            for (int d = 0; d < NUM_PORTS; d++) begin
                if (win_valid[d]) begin
                    rr_ptr[d] <= (win_idx[d] == LAST_IDX) ? '0 : win_idx[d] + 1'b1;
                end
                if (inject[d].valid) begin
                    out[d] <= inject[d];
                end else if (win_valid[d]) begin
                    out[d] <= req[win_idx[d]].flit;
                end else begin
                    out[d].valid <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== source/torus_router.sv ====
module torus_router #(
    parameter torus_router_pkg::coord_t cur         = '0,
    parameter int                       queue_depth = 8
) (
    input  logic                    clk,
    input  logic                    rst,

    // links, port order x+ y+ z+ x- y- z-
    input  torus_router_pkg::flit_t in_flit     [torus_router_pkg::NUM_PORTS],
    output torus_router_pkg::flit_t out_flit    [torus_router_pkg::NUM_PORTS],

    // kernel side
    input  torus_router_pkg::flit_t inject_flit [torus_router_pkg::NUM_PORTS],
    output torus_router_pkg::flit_t eject_flit  [torus_router_pkg::NUM_PORTS]
);

    torus_router_pkg::sw_req_t req   [torus_router_pkg::NUM_PORTS];
    logic                      grant [torus_router_pkg::NUM_PORTS];

    ////////////////////
    // input ports

    for (genvar i = 0; i < torus_router_pkg::NUM_PORTS; i++) begin : g_port
        input_port #(
            .cur        (cur),
            .queue_depth(queue_depth)
        ) u_input_port (
            .clk    (clk),
            .rst    (rst),
            .link_in(in_flit[i]),
            .grant  (grant[i]),
            .req    (req[i]),
            .eject  (eject_flit[i])
        );
    end

    ////////////////////
    // switch

    switch_alloc u_switch_alloc (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .inject(inject_flit),
        .grant (grant),
        .out   (out_flit)
    );

endmodule

// ==== source/torus_router_pkg.sv ====
package torus_router_pkg;

    ////////////////////
    // widths

    localparam int NUM_PORTS = 6;
    localparam int AXIS_W    = 3;
    localparam int PAYLOAD_W = 32;
    localparam int TAG_W     = 8;

    typedef logic [AXIS_W-1:0]    axis_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;
    typedef logic [TAG_W-1:0]     tag_t;

    ////////////////////
    // flit format

    // one node position in the mesh
    typedef struct packed {
        axis_t x;
        axis_t y;
        axis_t z;
    } coord_t;

    // valid sits on top, payload at the bottom
    typedef struct packed {
        logic     valid;
        coord_t   dst;
        coord_t   src;
        tag_t     tag;
        payload_t payload;
    } flit_t;

    ////////////////////
    // directions

    // output port index is the direction minus one
    typedef enum logic [2:0] {
        DIR_LOCAL = 3'd0,
        DIR_XPOS  = 3'd1,
        DIR_YPOS  = 3'd2,
        DIR_ZPOS  = 3'd3,
        DIR_XNEG  = 3'd4,
        DIR_YNEG  = 3'd5,
        DIR_ZNEG  = 3'd6
    } dir_e;

    // head of an input queue offered to the switch
    typedef struct packed {
        flit_t flit;
        dir_e  route;
    } sw_req_t;

endpackage

// ==== torus_router.f ====
+incdir+verif
source/torus_router_pkg.sv
source/flit_queue.sv
source/dor_route.sv
source/input_port.sv
source/switch_alloc.sv
source/torus_router.sv
verif/torus_router_tb.sv

// ==== verif/router_tests.svh ====
`ifndef ROUTER_TESTS_SVH
`define ROUTER_TESTS_SVH

    ////////////////////
    // directed tests

    task automatic reset_quiet();
        repeat (5) begin
            @(negedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                compare_value($sformatf("out_flit[%0d].valid", p),
                              32'(out_flit[p].valid), 0);
                compare_value($sformatf("eject_flit[%0d].valid", p),
                              32'(eject_flit[p].valid), 0);
            end
        end
        expect_idle();
    endtask

    task automatic route_all_inputs();
        torus_router_pkg::coord_t dsts [12];
        torus_router_pkg::flit_t  f;
        time                      sent;
        // the six neighbours come before the far nodes
        dsts = '{make_coord(3, 2, 2), make_coord(2, 3, 2), make_coord(2, 2, 3),
                 make_coord(1, 2, 2), make_coord(2, 1, 2), make_coord(2, 2, 1),
                 make_coord(5, 0, 0), make_coord(0, 7, 1), make_coord(2, 6, 0),
                 make_coord(2, 0, 7), make_coord(2, 2, 7), make_coord(7, 7, 7)};
        for (int i = 0; i < NUM_PORTS; i++) begin
            foreach (dsts[k]) begin
                f = make_flit(dsts[k]);
                send_on_input(i, f, sent);
                expect_flit(1'b0, expected_port(dsts[k]), f, sent, 1'b1);
                expect_idle();
            end
        end
    endtask

    task automatic eject_local();
        torus_router_pkg::flit_t f;
        time                     sent;
        for (int i = 0; i < NUM_PORTS; i++) begin
            f = make_flit(CUR);
            send_on_input(i, f, sent);
            expect_flit(1'b1, i, f, sent, 1'b1);
            expect_idle();
        end
    endtask

    task automatic contend_one_output();
        torus_router_pkg::flit_t sent_flits [NUM_PORTS];
        bit                      taken      [NUM_PORTS];
        torus_router_pkg::flit_t got;
        time                     seen;
        time                     last;
        int                      d;
        int                      hit;
        d = expected_port(make_coord(6, 1, 3));
        // all six inputs aim at the same output in one cycle
        @(posedge clk);
        for (int i = 0; i < NUM_PORTS; i++) begin
            sent_flits[i] = make_flit(make_coord(6, 1, 3));
            taken[i]      = 1'b0;
            in_flit[i]   <= sent_flits[i];
        end
        @(posedge clk);
        clear_inputs();
        last = 0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            wait_flit(1'b0, d, got, seen);
            hit = -1;
            for (int j = 0; j < NUM_PORTS; j++) begin
                if (!taken[j] && got === sent_flits[j]) begin
                    hit = j;
                end
            end
            assert (hit >= 0) else begin
                report_failure($sformatf("flit on out_flit[%0d] is unknown or repeated", d));
            end
            if (hit >= 0) begin
                taken[hit] = 1'b1;
            end
            if (k > 0 && got.valid) begin
                compare_value($sformatf("out_flit[%0d] cycles between flits", d),
                              int'((seen - last) / CLK_PERIOD), 1);
            end
            last = seen;
        end
        expect_idle();
    endtask

    task automatic inject_priority();
        torus_router_pkg::flit_t sw;
        torus_router_pkg::flit_t inj_a;
        torus_router_pkg::flit_t inj_b;
        sw    = make_flit(make_coord(2, 2, 5));
        inj_a = make_flit(make_coord(4, 0, 1));
        inj_b = make_flit(make_coord(0, 3, 6));
        @(posedge clk);
        in_flit[4] <= sw;
        // kernel owns z+ for the two cycles the request waits
        @(posedge clk);
        in_flit[4].valid <= 1'b0;
        inject_flit[2]   <= inj_a;
        @(posedge clk);
        inject_flit[2] <= inj_b;
        @(posedge clk);
        clear_inputs();
        expect_flit(1'b0, 2, inj_a, 0, 1'b0);
        expect_flit(1'b0, 2, inj_b, 0, 1'b0);
        expect_flit(1'b0, 2, sw, 0, 1'b0);
        expect_idle();
    endtask

    task automatic burst_order();
        torus_router_pkg::flit_t burst [5];
        // back to back on y+ and all bound for z-
        for (int k = 0; k < 5; k++) begin
            burst[k] = make_flit(make_coord(2, 2, 0));
            @(posedge clk);
            in_flit[1] <= burst[k];
        end
        @(posedge clk);
        clear_inputs();
        foreach (burst[k]) begin
            expect_flit(1'b0, 5, burst[k], 0, 1'b0);
        end
        expect_idle();
    endtask

`endif

// ==== verif/torus_router_tb.sv ====
module torus_router_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int  NUM_PORTS      = torus_router_pkg::NUM_PORTS;
    localparam time CLK_PERIOD     = 4;
    localparam int  TIMEOUT_CYCLES = 40;
    localparam torus_router_pkg::coord_t CUR = '{x: 3'd2, y: 3'd2, z: 3'd2};

    logic                    clk;
    logic                    rst;
    torus_router_pkg::flit_t in_flit     [NUM_PORTS];
    torus_router_pkg::flit_t inject_flit [NUM_PORTS];
    torus_router_pkg::flit_t out_flit    [NUM_PORTS];
    torus_router_pkg::flit_t eject_flit  [NUM_PORTS];

    // every valid flit seen and the time it showed up
    torus_router_pkg::flit_t out_q   [NUM_PORTS][$];
    time                     out_t   [NUM_PORTS][$];
    torus_router_pkg::flit_t eject_q [NUM_PORTS][$];
    time                     eject_t [NUM_PORTS][$];

    integer                 seed;
    torus_router_pkg::tag_t tag_count;
    int                     mismatches;
    int                     failures;

    torus_router #(
        .cur        (CUR),
        .queue_depth(8)
    ) u_torus_router (
        .clk        (clk),
        .rst        (rst),
        .in_flit    (in_flit),
        .out_flit   (out_flit),
        .inject_flit(inject_flit),
        .eject_flit (eject_flit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    ////////////////////
    // monitor

    // a registered output sampled here appeared one period ago
    always @(posedge clk) begin
        if (!rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (out_flit[p].valid) begin
                    out_q[p].push_back(out_flit[p]);
                    out_t[p].push_back($time - CLK_PERIOD);
                end
                if (eject_flit[p].valid) begin
                    eject_q[p].push_back(eject_flit[p]);
                    eject_t[p].push_back($time - CLK_PERIOD);
                end
            end
        end
    end

    ////////////////////
    // helpers

    function automatic torus_router_pkg::coord_t make_coord(int x, int y, int z);
        torus_router_pkg::coord_t c;
        c.x = torus_router_pkg::axis_t'(x);
        c.y = torus_router_pkg::axis_t'(y);
        c.z = torus_router_pkg::axis_t'(z);
        return c;
    endfunction

    function automatic torus_router_pkg::flit_t make_flit(torus_router_pkg::coord_t dst);
        torus_router_pkg::flit_t f;
        f.valid   = 1'b1;
        f.dst     = dst;
        f.src     = make_coord(1, 4, 6);
        f.tag     = tag_count;
        f.payload = $random(seed);
        tag_count = tag_count + 8'd1;
        return f;
    endfunction

    // dimension order x then y then z
    // -1 means the kernel
    function automatic int expected_port(torus_router_pkg::coord_t dst);
        if (dst.x != CUR.x) begin
            return (dst.x > CUR.x) ? 0 : 3;
        end
        if (dst.y != CUR.y) begin
            return (dst.y > CUR.y) ? 1 : 4;
        end
        if (dst.z != CUR.z) begin
            return (dst.z > CUR.z) ? 2 : 5;
        end
        return -1;
    endfunction

    task automatic compare_flit(string name, torus_router_pkg::flit_t got,
                                torus_router_pkg::flit_t exp);
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_failure(string msg);
        $display("ERROR t=%0t %s", $time, msg);
        failures++;
    endtask

    task automatic clear_inputs();
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_flit[p].valid     <= 1'b0;
            inject_flit[p].valid <= 1'b0;
        end
    endtask

    task automatic send_on_input(input int port, input torus_router_pkg::flit_t f,
                                 output time sent);
        @(posedge clk);
        in_flit[port] <= f;
        sent = $time;
        @(posedge clk);
        clear_inputs();
    endtask

    function automatic int queued(bit from_eject, int port);
        return from_eject ? eject_q[port].size() : out_q[port].size();
    endfunction

    task automatic wait_flit(input bit from_eject, input int port,
                             output torus_router_pkg::flit_t f, output time seen);
        int waited;
        waited = 0;
        f      = '0;
        seen   = 0;
        while (queued(from_eject, port) == 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        assert (queued(from_eject, port) != 0) else begin
            report_failure($sformatf("no flit arrived on %s[%0d] in time",
                                     from_eject ? "eject_flit" : "out_flit", port));
        end
        if (queued(from_eject, port) != 0) begin
            if (from_eject) begin
                f    = eject_q[port].pop_front();
                seen = eject_t[port].pop_front();
            end else begin
                f    = out_q[port].pop_front();
                seen = out_t[port].pop_front();
            end
        end
    endtask

    // latency is checked only on an idle router
    task automatic expect_flit(input bit from_eject, input int port,
                               input torus_router_pkg::flit_t exp, input time sent,
                               input bit timed);
        torus_router_pkg::flit_t got;
        time                     seen;
        string                   name;
        name = $sformatf("%s[%0d]", from_eject ? "eject_flit" : "out_flit", port);
        wait_flit(from_eject, port, got, seen);
        if (got.valid) begin
            compare_flit(name, got, exp);
            if (timed) begin
                compare_value({name, " latency"}, int'((seen - sent) / CLK_PERIOD), 2);
            end
        end
    endtask

    task automatic expect_idle();
        repeat (4) @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (out_q[p].size() == 0 && eject_q[p].size() == 0) else begin
                report_failure($sformatf("unexpected extra flit on port %0d", p));
            end
            out_q[p].delete();
            out_t[p].delete();
            eject_q[p].delete();
            eject_t[p].delete();
        end
    endtask

    `include "router_tests.svh"

    ////////////////////
    // main sequence

    initial begin
        seed       = 32;
        tag_count  = '0;
        mismatches = 0;
        failures   = 0;
        rst       <= 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_flit[p]     <= '0;
            inject_flit[p] <= '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_quiet();
        route_all_inputs();
        eject_local();
        contend_one_output();
        inject_priority();
        burst_order();
        $display("errors: %0d mismatches, %0d other", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
